// ==== rename_pkg.sv ====
package rename_pkg;

    // physical register file size
    localparam int prf_num = 64;
    // bits needed to index a physical register
    localparam int preg_w = 6;

    // architectural register file size
    localparam int arch_num = 32;
    // bits needed to index an architectural register
    localparam int areg_w = 5;

    // registers free after reset, these are pregs 32 to 63
    // pregs 0 to 31 start out as the identity mapping
    localparam int free_init = 32;

    // instructions renamed per group
    localparam int dispatch_w = 2;

    // writeback ports that clear busy bits each cycle
    localparam int wb_w = 4;

    // physical register index
    typedef logic [preg_w-1:0] preg_t;

    // architectural register index
    typedef logic [areg_w-1:0] areg_t;

endpackage

// ==== alloc_if.sv ====
`timescale 1ns/1ps

interface alloc_if;

    // lane wants a new preg, set by the map
    logic need_0;
    logic need_1;

    // free list can cover every raised need
    logic ready;

    // group accepted this cycle
    logic fire;

    // granted pregs in queue order
    rename_pkg::preg_t preg_0;
    rename_pkg::preg_t preg_1;

    // rename map raises needs and fires the group
    modport map_side (output need_0, need_1, fire, input ready, preg_0, preg_1);

    // free list answers with ready and the next free entries
    modport list_side (input need_0, need_1, fire, output ready, preg_0, preg_1);

    // busy table only watches the grants
    modport busy_side (input need_0, need_1, fire, preg_0, preg_1);

endinterface

// ==== wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;

    // one valid per writeback port
    logic valid_0;
    logic valid_1;
    logic valid_2;
    logic valid_3;

    // preg being written back on each port
    rename_pkg::preg_t preg_0;
    rename_pkg::preg_t preg_1;
    rename_pkg::preg_t preg_2;
    rename_pkg::preg_t preg_3;

    modport source (output valid_0, valid_1, valid_2, valid_3,
                    output preg_0, preg_1, preg_2, preg_3);

    modport sink (input valid_0, valid_1, valid_2, valid_3,
                  input preg_0, preg_1, preg_2, preg_3);

endinterface

// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    alloc_if.list_side        alloc,
    input  logic              commit_valid_0,
    input  logic              commit_valid_1,
    input  rename_pkg::preg_t commit_preg_0,
    input  rename_pkg::preg_t commit_preg_1
);

    // queue storage, one slot per physical register
    rename_pkg::preg_t mem [rename_pkg::prf_num];

    // pointers wrap for free since depth is a power of two
    logic [rename_pkg::preg_w-1:0] head;
    logic [rename_pkg::preg_w-1:0] tail;
    logic [rename_pkg::preg_w-1:0] head_nxt;
    logic [rename_pkg::preg_w-1:0] tail_nxt;

    // count needs one more bit to reach a full queue
    logic [rename_pkg::preg_w:0] count;

    // per-group counts, never above dispatch_w
    logic [$clog2(rename_pkg::dispatch_w+1)-1:0] need_n;
    logic [$clog2(rename_pkg::dispatch_w+1)-1:0] pop_n;
    logic [$clog2(rename_pkg::dispatch_w+1)-1:0] push_n;

    logic push_0;
    logic push_1;

    // number of pregs the current group asks for
    assign need_n = {1'b0, alloc.need_0} + {1'b0, alloc.need_1};

    // enough entries left for this group
    assign alloc.ready = (count >= (rename_pkg::preg_w+1)'(need_n));

    // lane 0 always takes the head
    assign alloc.preg_0 = mem[head];

    // lane 1 skips over the head only if lane 0 takes it
    assign head_nxt = head + 1'b1;
    assign alloc.preg_1 = alloc.need_0 ? mem[head_nxt] : mem[head];

    // only pop what was granted at an accepted group
    assign pop_n = alloc.fire ? need_n : '0;

    // preg 0 is hard-wired, a commit of it carries no register
    assign push_0 = commit_valid_0 && (commit_preg_0 != '0);
    assign push_1 = commit_valid_1 && (commit_preg_1 != '0);
    assign push_n = {1'b0, push_0} + {1'b0, push_1};

    // lane 1 lands behind lane 0 when both commit
    assign tail_nxt = push_0 ? tail + 1'b1 : tail;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            // reload the upper half of the file in order
            for (int i = 0; i < rename_pkg::free_init; i++) begin
                mem[i] <= rename_pkg::preg_t'(rename_pkg::free_init + i);
            end
            head  <= '0;
            tail  <= rename_pkg::preg_w'(rename_pkg::free_init);
            count <= (rename_pkg::preg_w+1)'(rename_pkg::free_init);
        end else begin
            if (push_0) begin
                mem[tail] <= commit_preg_0;
            end
            if (push_1) begin
                mem[tail_nxt] <= commit_preg_1;
            end
            // pop and push share the edge
            head  <= head + rename_pkg::preg_w'(pop_n);
            tail  <= tail + rename_pkg::preg_w'(push_n);
            count <= count + (rename_pkg::preg_w+1)'(push_n)
                           - (rename_pkg::preg_w+1)'(pop_n);
        end
    end

endmodule

// ==== rename_map.sv ====
`timescale 1ns/1ps

module rename_map (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_dst_we_0,
    input  logic              in_dst_we_1,
    input  rename_pkg::areg_t in_dst_areg_0,
    input  rename_pkg::areg_t in_dst_areg_1,
    input  rename_pkg::areg_t in_src1_areg_0,
    input  rename_pkg::areg_t in_src1_areg_1,
    input  rename_pkg::areg_t in_src2_areg_0,
    input  rename_pkg::areg_t in_src2_areg_1,
    alloc_if.map_side         alloc,
    output logic              out_valid,
    output rename_pkg::preg_t out_dst_preg_0,
    output rename_pkg::preg_t out_dst_preg_1,
    output rename_pkg::preg_t out_old_preg_0,
    output rename_pkg::preg_t out_old_preg_1,
    output rename_pkg::preg_t out_src1_preg_0,
    output rename_pkg::preg_t out_src1_preg_1,
    output rename_pkg::preg_t out_src2_preg_0,
    output rename_pkg::preg_t out_src2_preg_1,
    output rename_pkg::preg_t src1_preg_0,
    output rename_pkg::preg_t src1_preg_1,
    output rename_pkg::preg_t src2_preg_0,
    output rename_pkg::preg_t src2_preg_1
);

    // speculative map, one preg per arch register
    rename_pkg::preg_t map_q [rename_pkg::arch_num];

    // previous mapping of each destination
    rename_pkg::preg_t old_0;
    rename_pkg::preg_t old_1;

    // lane 1 names the register lane 0 is renaming
    logic fwd_src1;
    logic fwd_src2;
    logic fwd_dst;

    // r0 never gets a new preg
    assign alloc.need_0 = in_valid && in_dst_we_0 && (in_dst_areg_0 != '0);
    assign alloc.need_1 = in_valid && in_dst_we_1 && (in_dst_areg_1 != '0);

    // accept needs the free list to cover the whole group
    assign alloc.fire = in_valid && alloc.ready;

    // lane 0 reads the table as is
    assign src1_preg_0 = map_q[in_src1_areg_0];
    assign src2_preg_0 = map_q[in_src2_areg_0];
    assign old_0       = map_q[in_dst_areg_0];

    // need_0 already excludes r0, so r0 reads stay at preg 0
    assign fwd_src1 = alloc.need_0 && (in_src1_areg_1 == in_dst_areg_0);
    assign fwd_src2 = alloc.need_0 && (in_src2_areg_1 == in_dst_areg_0);
    assign fwd_dst  = alloc.need_0 && (in_dst_areg_1 == in_dst_areg_0);

    // lane 1 sees lane 0's new preg instead of the stale entry
    assign src1_preg_1 = fwd_src1 ? alloc.preg_0 : map_q[in_src1_areg_1];
    assign src2_preg_1 = fwd_src2 ? alloc.preg_0 : map_q[in_src2_areg_1];
    assign old_1       = fwd_dst ? alloc.preg_0 : map_q[in_dst_areg_1];

    // table update
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            // identity map, arch reg n lives in preg n
            for (int i = 0; i < rename_pkg::arch_num; i++) begin
                map_q[i] <= rename_pkg::preg_t'(i);
            end
        end else if (alloc.fire) begin
            if (alloc.need_0) begin
                map_q[in_dst_areg_0] <= alloc.preg_0;
            end
            // written last so lane 1 wins a shared destination
            if (alloc.need_1) begin
                map_q[in_dst_areg_1] <= alloc.preg_1;
            end
        end
    end

    // result valid one cycle after accept
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= alloc.fire;
        end
    end

    // result payload, only meaningful with out_valid
    always_ff @(posedge clk) begin
        if (alloc.fire) begin
            // lanes without a real destination report preg 0 twice
            out_dst_preg_0  <= alloc.need_0 ? alloc.preg_0 : '0;
            out_dst_preg_1  <= alloc.need_1 ? alloc.preg_1 : '0;
            out_old_preg_0  <= alloc.need_0 ? old_0 : '0;
            out_old_preg_1  <= alloc.need_1 ? old_1 : '0;
            out_src1_preg_0 <= src1_preg_0;
            out_src1_preg_1 <= src1_preg_1;
            out_src2_preg_0 <= src2_preg_0;
            out_src2_preg_1 <= src2_preg_1;
        end
    end

endmodule

// ==== busy_table.sv ====
`timescale 1ns/1ps

module busy_table (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    alloc_if.busy_side        alloc,
    wb_if.sink                wb,
    input  rename_pkg::preg_t rd_preg_0,
    input  rename_pkg::preg_t rd_preg_1,
    input  rename_pkg::preg_t rd_preg_2,
    input  rename_pkg::preg_t rd_preg_3,
    output logic              busy_0,
    output logic              busy_1,
    output logic              busy_2,
    output logic              busy_3
);

    // one bit per preg, set while a result is outstanding
    logic [rename_pkg::prf_num-1:0] busy_q;

    // pregs granted and pregs written back this cycle
    logic [rename_pkg::prf_num-1:0] set_vec;
    logic [rename_pkg::prf_num-1:0] clr_vec;

    // writeback ports gathered for looping
    logic [rename_pkg::wb_w-1:0] wb_valid;
    rename_pkg::preg_t           wb_preg [rename_pkg::wb_w];

    // read ports, 0/1 are lane 0 src1/src2, 2/3 are lane 1
    rename_pkg::preg_t rd   [4];
    logic [3:0]        busy_now;

    assign wb_valid = {wb.valid_3, wb.valid_2, wb.valid_1, wb.valid_0};
    assign wb_preg[0] = wb.preg_0;
    assign wb_preg[1] = wb.preg_1;
    assign wb_preg[2] = wb.preg_2;
    assign wb_preg[3] = wb.preg_3;

    assign rd[0] = rd_preg_0;
    assign rd[1] = rd_preg_1;
    assign rd[2] = rd_preg_2;
    assign rd[3] = rd_preg_3;

    always_comb begin
        clr_vec = '0;
        for (int i = 0; i < rename_pkg::wb_w; i++) begin
            if (wb_valid[i]) begin
                clr_vec[wb_preg[i]] = 1'b1;
            end
        end
        set_vec = '0;
        if (alloc.fire && alloc.need_0) begin
            set_vec[alloc.preg_0] = 1'b1;
        end
        if (alloc.fire && alloc.need_1) begin
            set_vec[alloc.preg_1] = 1'b1;
        end
        // preg 0 is the zero register and is never busy
        set_vec[0] = 1'b0;
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // same-cycle writeback already counts as ready
            busy_now[i] = busy_q[rd[i]] && !clr_vec[rd[i]];
        end
        // lane 1 reading lane 0's fresh destination waits on it
        busy_now[2] = busy_now[2] || (alloc.need_0 && (rd[2] == alloc.preg_0));
        busy_now[3] = busy_now[3] || (alloc.need_0 && (rd[3] == alloc.preg_0));
    end

    // clear beats set when both name the same preg
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q | set_vec) & ~clr_vec;
        end
    end

    // captured with the rename result
    always_ff @(posedge clk) begin
        if (alloc.fire) begin
            busy_0 <= busy_now[0];
            busy_1 <= busy_now[1];
            busy_2 <= busy_now[2];
            busy_3 <= busy_now[3];
        end
    end

endmodule

// ==== rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    // dispatch side
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              in_dst_we_0,
    input  logic              in_dst_we_1,
    input  rename_pkg::areg_t in_dst_areg_0,
    input  rename_pkg::areg_t in_dst_areg_1,
    input  rename_pkg::areg_t in_src1_areg_0,
    input  rename_pkg::areg_t in_src1_areg_1,
    input  rename_pkg::areg_t in_src2_areg_0,
    input  rename_pkg::areg_t in_src2_areg_1,
    // rename result, one cycle after accept
    output logic              out_valid,
    output rename_pkg::preg_t out_dst_preg_0,
    output rename_pkg::preg_t out_dst_preg_1,
    output rename_pkg::preg_t out_old_preg_0,
    output rename_pkg::preg_t out_old_preg_1,
    output rename_pkg::preg_t out_src1_preg_0,
    output rename_pkg::preg_t out_src1_preg_1,
    output rename_pkg::preg_t out_src2_preg_0,
    output rename_pkg::preg_t out_src2_preg_1,
    output logic              out_src1_busy_0,
    output logic              out_src1_busy_1,
    output logic              out_src2_busy_0,
    output logic              out_src2_busy_1,
    // writeback clears
    input  logic              wb_valid_0,
    input  logic              wb_valid_1,
    input  logic              wb_valid_2,
    input  logic              wb_valid_3,
    input  rename_pkg::preg_t wb_preg_0,
    input  rename_pkg::preg_t wb_preg_1,
    input  rename_pkg::preg_t wb_preg_2,
    input  rename_pkg::preg_t wb_preg_3,
    // commit releases
    input  logic              commit_valid_0,
    input  logic              commit_valid_1,
    input  rename_pkg::preg_t commit_preg_0,
    input  rename_pkg::preg_t commit_preg_1
);

    alloc_if alloc_bus ();
    wb_if    wb_bus ();

    // unregistered source lookups feeding the busy reads
    rename_pkg::preg_t src1_preg_0;
    rename_pkg::preg_t src1_preg_1;
    rename_pkg::preg_t src2_preg_0;
    rename_pkg::preg_t src2_preg_1;

    // dispatch stalls only on free-list space
    assign in_ready = alloc_bus.ready;

    assign wb_bus.valid_0 = wb_valid_0;
    assign wb_bus.valid_1 = wb_valid_1;
    assign wb_bus.valid_2 = wb_valid_2;
    assign wb_bus.valid_3 = wb_valid_3;
    assign wb_bus.preg_0  = wb_preg_0;
    assign wb_bus.preg_1  = wb_preg_1;
    assign wb_bus.preg_2  = wb_preg_2;
    assign wb_bus.preg_3  = wb_preg_3;

    rename_map u_map (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .in_valid(in_valid),
        .in_dst_we_0(in_dst_we_0), .in_dst_we_1(in_dst_we_1),
        .in_dst_areg_0(in_dst_areg_0), .in_dst_areg_1(in_dst_areg_1),
        .in_src1_areg_0(in_src1_areg_0), .in_src1_areg_1(in_src1_areg_1),
        .in_src2_areg_0(in_src2_areg_0), .in_src2_areg_1(in_src2_areg_1),
        .alloc(alloc_bus.map_side),
        .out_valid(out_valid),
        .out_dst_preg_0(out_dst_preg_0), .out_dst_preg_1(out_dst_preg_1),
        .out_old_preg_0(out_old_preg_0), .out_old_preg_1(out_old_preg_1),
        .out_src1_preg_0(out_src1_preg_0), .out_src1_preg_1(out_src1_preg_1),
        .out_src2_preg_0(out_src2_preg_0), .out_src2_preg_1(out_src2_preg_1),
        .src1_preg_0(src1_preg_0), .src1_preg_1(src1_preg_1),
        .src2_preg_0(src2_preg_0), .src2_preg_1(src2_preg_1)
    );

    free_list u_free (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .alloc(alloc_bus.list_side),
        .commit_valid_0(commit_valid_0), .commit_valid_1(commit_valid_1),
        .commit_preg_0(commit_preg_0), .commit_preg_1(commit_preg_1)
    );

    // read ports in lane order, src1 then src2
    busy_table u_busy (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .alloc(alloc_bus.busy_side),
        .wb(wb_bus.sink),
        .rd_preg_0(src1_preg_0), .rd_preg_1(src2_preg_0),
        .rd_preg_2(src1_preg_1), .rd_preg_3(src2_preg_1),
        .busy_0(out_src1_busy_0), .busy_1(out_src2_busy_0),
        .busy_2(out_src1_busy_1), .busy_3(out_src2_busy_1)
    );

endmodule

// ==== tb_rename_stage.sv ====
`timescale 1ns/1ps

module tb_rename_stage;

    // longest run is about 350 cycles, limit leaves wide margin
    localparam int max_cycles = 2000;

    logic clk = 1'b0;
    logic rst_n, flush, in_valid, in_ready, in_dst_we_0, in_dst_we_1;
    rename_pkg::areg_t in_dst_areg_0, in_dst_areg_1, in_src1_areg_0, in_src1_areg_1;
    rename_pkg::areg_t in_src2_areg_0, in_src2_areg_1;
    logic out_valid, out_src1_busy_0, out_src1_busy_1, out_src2_busy_0, out_src2_busy_1;
    rename_pkg::preg_t out_dst_preg_0, out_dst_preg_1, out_old_preg_0, out_old_preg_1;
    rename_pkg::preg_t out_src1_preg_0, out_src1_preg_1, out_src2_preg_0, out_src2_preg_1;
    logic wb_valid_0, wb_valid_1, wb_valid_2, wb_valid_3, commit_valid_0, commit_valid_1;
    rename_pkg::preg_t wb_preg_0, wb_preg_1, wb_preg_2, wb_preg_3, commit_preg_0, commit_preg_1;

    // reference model state
    int map_m [rename_pkg::arch_num];
    bit busy_m [rename_pkg::prf_num];
    int free_q [$];
    // old pregs waiting to be committed
    int retire_q [$];
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycles = 0;

    rename_stage uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0d actual %0d", what, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // identity map, nothing busy, 32..63 free in order
    task automatic model_reset();
        for (int i = 0; i < rename_pkg::arch_num; i++) map_m[i] = i;
        for (int i = 0; i < rename_pkg::prf_num; i++) busy_m[i] = 1'b0;
        free_q.delete();
        retire_q.delete();
        for (int i = 0; i < rename_pkg::free_init; i++) free_q.push_back(32 + i);
    endtask

    // preg cleared by a writeback driven this cycle
    function automatic bit wb_hits(input int p);
        return (wb_valid_0 && wb_preg_0 == p) || (wb_valid_1 && wb_preg_1 == p) ||
               (wb_valid_2 && wb_preg_2 == p) || (wb_valid_3 && wb_preg_3 == p);
    endfunction

    // random busy preg, 0 when none is busy
    function automatic int pick_busy();
        int list [$];
        for (int i = 0; i < rename_pkg::prf_num; i++) begin
            if (busy_m[i]) list.push_back(i);
        end
        if (list.size() == 0) return 0;
        return list[$urandom % list.size()];
    endfunction

    task automatic drive_wb(input logic [3:0] v, input int p0, input int p1,
                            input int p2, input int p3);
        {wb_valid_3, wb_valid_2, wb_valid_1, wb_valid_0} = v;
        wb_preg_0 = rename_pkg::preg_t'(p0);
        wb_preg_1 = rename_pkg::preg_t'(p1);
        wb_preg_2 = rename_pkg::preg_t'(p2);
        wb_preg_3 = rename_pkg::preg_t'(p3);
    endtask

    task automatic drive_commit(input logic v0, input int p0, input logic v1, input int p1);
        commit_valid_0 = v0;
        commit_preg_0  = rename_pkg::preg_t'(p0);
        commit_valid_1 = v1;
        commit_preg_1  = rename_pkg::preg_t'(p1);
    endtask

    task automatic set_group(input logic we0, input rename_pkg::areg_t d0,
                             input rename_pkg::areg_t a0, input rename_pkg::areg_t b0,
                             input logic we1, input rename_pkg::areg_t d1,
                             input rename_pkg::areg_t a1, input rename_pkg::areg_t b1);
        in_valid = 1'b1;
        in_dst_we_0 = we0;
        in_dst_areg_0 = d0;
        in_src1_areg_0 = a0;
        in_src2_areg_0 = b0;
        in_dst_we_1 = we1;
        in_dst_areg_1 = d1;
        in_src1_areg_1 = a1;
        in_src2_areg_1 = b1;
    endtask

    // writebacks clear after sets, commits push lane 0 first
    task automatic apply_side();
        for (int i = 0; i < rename_pkg::prf_num; i++) begin
            if (wb_hits(i)) busy_m[i] = 1'b0;
        end
        if (commit_valid_0 && commit_preg_0 != 0) free_q.push_back(commit_preg_0);
        if (commit_valid_1 && commit_preg_1 != 0) free_q.push_back(commit_preg_1);
        drive_wb(4'b0000, 0, 0, 0, 0);
        drive_commit(1'b0, 0, 1'b0, 0);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        apply_side();
    endtask

    // a group offered while flushing must be dropped
    task automatic do_flush();
        set_group(0, 0, 0, 0, 0, 0, 0, 0);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        in_valid = 1'b0;
        model_reset();
        check("flush out_valid", 0, out_valid);
    endtask

    // waits for in_ready, accepts the driven group and checks the result
    task automatic accept_group(input string name);
        bit n0, n1, b10, b20, b11, b21;
        int p0, p1, s10, s20, s11, s21, o0, o1;
        // in_ready follows the new group combinationally
        #1;
        while (!in_ready) tick();
        n0 = in_dst_we_0 && (in_dst_areg_0 != 0);
        n1 = in_dst_we_1 && (in_dst_areg_1 != 0);
        p0 = n0 ? free_q[0] : 0;
        p1 = n1 ? (n0 ? free_q[1] : free_q[0]) : 0;
        s10 = map_m[in_src1_areg_0];
        s20 = map_m[in_src2_areg_0];
        b10 = busy_m[s10] && !wb_hits(s10);
        b20 = busy_m[s20] && !wb_hits(s20);
        // lane 1 depends on lane 0's fresh destination
        if (n0 && in_src1_areg_1 == in_dst_areg_0) begin
            s11 = p0;
            b11 = 1'b1;
        end else begin
            s11 = map_m[in_src1_areg_1];
            b11 = busy_m[s11] && !wb_hits(s11);
        end
        if (n0 && in_src2_areg_1 == in_dst_areg_0) begin
            s21 = p0;
            b21 = 1'b1;
        end else begin
            s21 = map_m[in_src2_areg_1];
            b21 = busy_m[s21] && !wb_hits(s21);
        end
        o0 = n0 ? map_m[in_dst_areg_0] : 0;
        o1 = n1 ? ((n0 && in_dst_areg_1 == in_dst_areg_0) ? p0 : map_m[in_dst_areg_1]) : 0;
        @(posedge clk);
        #1;
        if (n0) begin
            void'(free_q.pop_front());
            map_m[in_dst_areg_0] = p0;
            busy_m[p0] = 1'b1;
            retire_q.push_back(o0);
        end
        // lane 1 written last so it owns a shared destination
        if (n1) begin
            void'(free_q.pop_front());
            map_m[in_dst_areg_1] = p1;
            busy_m[p1] = 1'b1;
            retire_q.push_back(o1);
        end
        apply_side();
        in_valid = 1'b0;
        check({name, " out_valid"}, 1, out_valid);
        check({name, " dst0"}, p0, out_dst_preg_0);
        check({name, " dst1"}, p1, out_dst_preg_1);
        check({name, " old0"}, o0, out_old_preg_0);
        check({name, " old1"}, o1, out_old_preg_1);
        check({name, " src1_0"}, s10, out_src1_preg_0);
        check({name, " src2_0"}, s20, out_src2_preg_0);
        check({name, " src1_1"}, s11, out_src1_preg_1);
        check({name, " src2_1"}, s21, out_src2_preg_1);
        check({name, " busy1_0"}, b10, out_src1_busy_0);
        check({name, " busy2_0"}, b20, out_src2_busy_0);
        check({name, " busy1_1"}, b11, out_src1_busy_1);
        check({name, " busy2_1"}, b21, out_src2_busy_1);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s done with %0d failing checks", name, fail_cnt - fails_before);
    endtask

    initial begin
        int start, c0, c1, seed_val;
        seed_val = $urandom(32'h90455028);
        rst_n = 1'b0;
        flush = 1'b0;
        set_group(0, 0, 0, 0, 0, 0, 0, 0);
        in_valid = 1'b0;
        drive_wb(4'b0000, 0, 0, 0, 0);
        drive_commit(1'b0, 0, 1'b0, 0);
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // r5 gets the first free preg
        start = fail_cnt;
        set_group(1, 5, 3, 4, 0, 0, 0, 0);
        accept_group("basic");
        check("basic dst", 32, out_dst_preg_0);
        check("basic old", 5, out_old_preg_0);
        check("basic src1", 3, out_src1_preg_0);
        check("basic busy", 0, out_src1_busy_0);
        report_test("basic", start);

        // lane 1 reads r7 written by lane 0, then both lanes write r9
        start = fail_cnt;
        set_group(1, 7, 1, 2, 1, 8, 7, 7);
        accept_group("dep");
        check("dep fwd src1", 33, out_src1_preg_1);
        check("dep fwd busy", 1, out_src1_busy_1);
        set_group(1, 9, 0, 0, 1, 9, 0, 0);
        accept_group("same dst");
        set_group(0, 0, 9, 0, 0, 0, 0, 0);
        accept_group("same dst read");
        check("same dst lane 1 wins", 36, out_src1_preg_0);
        report_test("dependency", start);

        // r7=33 and r8=34 busy, r0 never
        start = fail_cnt;
        set_group(0, 0, 8, 0, 0, 0, 0, 0);
        accept_group("wb before");
        check("wb before busy", 1, out_src1_busy_0);
        drive_wb(4'b0100, 0, 0, 33, 0);
        tick();
        drive_wb(4'b1011, 35, 36, 0, 34);
        set_group(1, 0, 7, 8, 0, 0, 9, 0);
        accept_group("wb");
        check("wb cleared", 0, out_src1_busy_0);
        check("wb same cycle", 0, out_src2_busy_0);
        check("wb r0 dst", 0, out_dst_preg_0);
        check("wb r0 busy", 0, out_src2_busy_1);
        report_test("writeback", start);

        // 32 allocations empty the free list
        start = fail_cnt;
        do_flush();
        for (int i = 0; i < 16; i++) begin
            set_group(1, i + 1, 0, 0, 1, i + 16, 0, 0);
            accept_group("fill");
        end
        set_group(1, 3, 5, 6, 1, 4, 3, 0);
        #1;
        check("full in_ready", 0, in_ready);
        tick();
        check("held out_valid", 0, out_valid);
        check("held in_ready", 0, in_ready);
        c0 = retire_q.pop_front();
        c1 = retire_q.pop_front();
        drive_commit(1'b1, c0, 1'b1, c1);
        tick();
        check("refill in_ready", 1, in_ready);
        accept_group("refill");
        check("refill dst0", c0, out_dst_preg_0);
        check("refill dst1", c1, out_dst_preg_1);
        report_test("exhaustion", start);

        // pregs 1 and 16 are busy before the flush and read through r1 and r16 after
        start = fail_cnt;
        do_flush();
        set_group(1, 3, 1, 16, 1, 4, 3, 0);
        accept_group("flush");
        check("flush dst0", 32, out_dst_preg_0);
        check("flush old0", 3, out_old_preg_0);
        check("flush src1", 1, out_src1_preg_0);
        check("flush busy1", 0, out_src1_busy_0);
        check("flush busy2", 0, out_src2_busy_0);
        report_test("flush", start);

        // mixed groups, writebacks and commits against the model
        start = fail_cnt;
        for (int i = 0; i < 200; i++) begin
            case ($urandom % 4)
                0, 1: begin
                    if (free_q.size() >= 2) begin
                        drive_wb($urandom % 16, pick_busy(), pick_busy(), pick_busy(),
                                 pick_busy());
                        set_group($urandom % 2, $urandom % 32, $urandom % 32, $urandom % 32,
                                  $urandom % 2, $urandom % 32, $urandom % 32, $urandom % 32);
                        accept_group("random");
                    end
                end
                2: begin
                    drive_wb($urandom % 16, pick_busy(), pick_busy(), pick_busy(),
                             pick_busy());
                    tick();
                end
                default: begin
                    if (retire_q.size() >= 2) begin
                        c0 = retire_q.pop_front();
                        c1 = retire_q.pop_front();
                        drive_commit(1'b1, c0, $urandom % 2, c1);
                        // a skipped lane 1 stays in the retire queue
                        if (!commit_valid_1) retire_q.push_front(c1);
                        tick();
                    end
                end
            endcase
        end
        report_test("random", start);

        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rename_pkg.sv
alloc_if.sv
wb_if.sv
free_list.sv
rename_map.sv
busy_table.sv
rename_stage.sv
tb_rename_stage.sv
